/* btc_settings.svh */
// width and size macros of the decoder datapath
`ifndef BTC_SETTINGS_SVH
`define BTC_SETTINGS_SVH

// --------------------
// datapath widths
// --------------------

// signed soft input
`define BTC_LLR_W 8

// user tag carried with each frame
`define BTC_TAG_W 8

// oerr and onum counters
`define BTC_ERR_W 16

// --------------------
// geometry
// --------------------

// LLRs per buffer word, one per lane
`define BTC_DEC_NUM 8

// longest row or column
`define BTC_LEN_MAX 32

`endif

/* btc_mode_pkg.sv */
// code mode enum, state machine enums and mode length decode
`default_nettype none

package btc_mode_pkg;

  // row or column length select, value 3 unused
  typedef enum logic [1:0] {
    CODE_LEN_8  = 2'd0,
    CODE_LEN_16 = 2'd1,
    CODE_LEN_32 = 2'd2
  } btc_code_mode_t;

  // input framing
  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_FRAME
  } src_state_t;

  // word walk of one frame
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_READ,
    ENG_DRAIN
  } eng_state_t;

  // serial readout
  typedef enum logic [1:0] {
    SINK_IDLE,
    SINK_READ,
    SINK_EOP,
    SINK_RELEASE
  } sink_state_t;

  // log2 of the length picked by a mode
  function automatic int code_len_log2(btc_code_mode_t mode);
    case (mode)
      CODE_LEN_8:  return 3;
      CODE_LEN_16: return 4;
      default:     return 5;
    endcase
  endfunction

endpackage

`default_nettype wire

/* btc_data_pkg.sv */
// data vector, address and tag field types of the decoder
`default_nettype none

`include "btc_settings.svh"

package btc_data_pkg;

  // --------------------
  // frame sizes
  // --------------------

  localparam int FRAME_BITS_MAX  = `BTC_LEN_MAX * `BTC_LEN_MAX;
  localparam int FRAME_WORDS_MAX = FRAME_BITS_MAX / `BTC_DEC_NUM;

  // --------------------
  // tag layout
  // --------------------

  localparam int MODE_W    = $bits(btc_mode_pkg::btc_code_mode_t);
  // {xmode, ymode, tag}
  localparam int IN_TAG_W  = 2 * MODE_W + `BTC_TAG_W;
  // {decfail, err, in tag}
  localparam int OUT_TAG_W = IN_TAG_W + `BTC_ERR_W + 1;

  // field positions
  localparam int TAG_YMODE_LSB  = `BTC_TAG_W;
  localparam int TAG_XMODE_LSB  = `BTC_TAG_W + MODE_W;
  localparam int OT_ERR_LSB     = IN_TAG_W;
  localparam int OT_DECFAIL_BIT = IN_TAG_W + `BTC_ERR_W;

  // --------------------
  // vectors
  // --------------------

  typedef logic signed [`BTC_LLR_W-1:0]            llr_t;
  // lane i sits at bits [i*LLR_W +: LLR_W]
  typedef logic [`BTC_DEC_NUM*`BTC_LLR_W-1:0]      llr_word_t;
  typedef logic [`BTC_DEC_NUM-1:0]                 bit_word_t;
  typedef logic [`BTC_TAG_W-1:0]                   tag_t;
  typedef logic [`BTC_ERR_W-1:0]                   err_t;

  // addresses
  typedef logic [$clog2(FRAME_BITS_MAX)-1:0]       ibuf_waddr_t;
  typedef logic [$clog2(FRAME_WORDS_MAX)-1:0]      word_addr_t;
  typedef logic [$clog2(FRAME_BITS_MAX)-1:0]       obuf_raddr_t;

  // tags
  typedef logic [IN_TAG_W-1:0]                     in_tag_t;
  typedef logic [OUT_TAG_W-1:0]                    out_tag_t;

endpackage

`default_nettype wire

/* btc_buf_if.sv */
// buffer write side, read side and status flags with modports
`timescale 1ns/1ps
`default_nettype none

interface btc_buf_if #(
  parameter int WADDR_W = 10,
  parameter int WDAT_W  = 8,
  parameter int RADDR_W = 7,
  parameter int RDAT_W  = 64,
  parameter int TAG_W   = 12
);

  // write side
  logic               write;
  logic               wfull;
  logic [WADDR_W-1:0] waddr;
  logic [WDAT_W-1:0]  wdat;
  logic [TAG_W-1:0]   wtag;

  // status levels
  logic               wempty;
  logic               rfull;

  // read side
  logic [RADDR_W-1:0] raddr;
  logic               rempty;
  // rdat one cycle after raddr
  logic [RDAT_W-1:0]  rdat;
  logic [TAG_W-1:0]   rtag;

  modport writer (output write, wfull, waddr, wdat, wtag, input wempty);

  modport buffer (
    input  write, wfull, waddr, wdat, wtag, raddr, rempty,
    output wempty, rfull, rdat, rtag
  );

  modport reader (output raddr, rempty, input rfull, rdat, rtag);

endinterface

`default_nettype wire

/* btc_dwc_buffer.sv */
// single bank frame buffer with width conversion, full flag and tag register
`timescale 1ns/1ps
`default_nettype none

module btc_dwc_buffer #(
  // write port width
  parameter int WDAT_W        = 8,
  // log2 of write width over read width
  // negative for narrow write, positive for narrow read
  parameter int WR_RATIO_LOG2 = -3
) (
  input logic       iclkin,
  input logic       rst,
  btc_buf_if.buffer bus
);

  import btc_data_pkg::*;

  localparam int LANE_W   = (WR_RATIO_LOG2 < 0) ? -WR_RATIO_LOG2 : WR_RATIO_LOG2;
  localparam int LANES    = 1 << LANE_W;
  localparam int NARROW_W = (WR_RATIO_LOG2 < 0) ? WDAT_W : WDAT_W / LANES;
  localparam int WORDS    = FRAME_BITS_MAX / LANES;
  localparam int WORD_AW  = $clog2(WORDS);

  // one wide word per row of lanes
  logic [LANES-1:0][NARROW_W-1:0] mem [WORDS];
  logic                           full;

  // --------------------
  // memory
  // --------------------

  // narrow address is {word, lane}
  if (WR_RATIO_LOG2 < 0) begin : g_narrow_write
    always_ff @(posedge iclkin) begin
      if (bus.write) begin
        mem[bus.waddr[LANE_W +: WORD_AW]][bus.waddr[LANE_W-1:0]] <= bus.wdat;
      end
      bus.rdat <= mem[bus.raddr];
    end
  end else begin : g_narrow_read
    always_ff @(posedge iclkin) begin
      if (bus.write) begin
        mem[bus.waddr] <= bus.wdat;
      end
      bus.rdat <= mem[bus.raddr[LANE_W +: WORD_AW]][bus.raddr[LANE_W-1:0]];
    end
  end

  // --------------------
  // flags and tag
  // --------------------

  // wfull hands the frame to the reader, rempty hands it back
  always_ff @(posedge iclkin) begin
    if (rst) begin
      full <= 1'b0;
    end else if (bus.wfull) begin
      full <= 1'b1;
    end else if (bus.rempty) begin
      full <= 1'b0;
    end
  end

  // tag travels with the frame
  always_ff @(posedge iclkin) begin
    if (bus.wfull) begin
      bus.rtag <= bus.wtag;
    end
  end

  assign bus.wempty = !full;
  assign bus.rfull  = full;

endmodule

`default_nettype wire

/* btc_dec_source.sv */
// input framing, LLR write address counter and ordy/obusy levels
`timescale 1ns/1ps
`default_nettype none

module btc_dec_source (
  input  logic                          iclkin,
  input  logic                          rst,
  input  logic                          ival,
  input  logic                          isop,
  input  logic                          ieop,
  input  btc_data_pkg::llr_t            llr,
  input  btc_data_pkg::tag_t            tag,
  input  btc_mode_pkg::btc_code_mode_t  xmode,
  input  btc_mode_pkg::btc_code_mode_t  ymode,
  output logic                          ordy,
  output logic                          obusy,
  btc_buf_if.writer                     wr
);

  import btc_mode_pkg::*;
  import btc_data_pkg::*;

  src_state_t  state;
  ibuf_waddr_t waddr;
  in_tag_t     tag_r;
  logic        sop_ok;
  logic        in_frame;

  // ordy offers room for a new frame, obusy covers the frame body
  assign ordy     = (state == SRC_IDLE) && wr.wempty;
  assign obusy    = (state == SRC_FRAME);
  assign in_frame = (state == SRC_FRAME);
  assign sop_ok   = ival && isop && ordy;

  // fsm and address counter
  always_ff @(posedge iclkin) begin
    if (rst) begin
      state <= SRC_IDLE;
      waddr <= '0;
    end else begin
      case (state)
        SRC_IDLE: begin
          if (sop_ok) begin
            // isop LLR goes to address 0
            state <= SRC_FRAME;
            waddr <= ibuf_waddr_t'(1);
          end
        end
        SRC_FRAME: begin
          if (ival) begin
            waddr <= waddr + 1'b1;
            if (ieop) begin
              state <= SRC_IDLE;
            end
          end
        end
        default: state <= SRC_IDLE;
      endcase
    end
  end

  // modes and tag of the frame
  always_ff @(posedge iclkin) begin
    if (sop_ok) begin
      tag_r <= {xmode, ymode, tag};
    end
  end

  // LLR stored on the edge it is accepted
  assign wr.write = sop_ok || (in_frame && ival);
  assign wr.waddr = in_frame ? waddr : '0;
  assign wr.wdat  = llr;
  assign wr.wfull = in_frame && ival && ieop;
  assign wr.wtag  = tag_r;

endmodule

`default_nettype wire

/* btc_dec_engine.sv */
// word walk with hard decisions, row parity check and result tag
`timescale 1ns/1ps
`default_nettype none

`include "btc_settings.svh"

module btc_dec_engine (
  input logic       iclkin,
  input logic       rst,
  btc_buf_if.reader rd,
  btc_buf_if.writer wr
);

  import btc_mode_pkg::*;
  import btc_data_pkg::*;

  localparam int LANE_LOG2 = $clog2(`BTC_DEC_NUM);

  eng_state_t state;
  in_tag_t    itag;
  out_tag_t   otag;
  int         xlog;
  int         ylog;
  word_addr_t row_mask;
  word_addr_t last_addr;
  word_addr_t raddr;
  logic       rd_last;

  // stage 1, read data valid
  logic       v1;
  word_addr_t a1;
  logic       last1;
  llr_word_t  rword;
  bit_word_t  dec_bits;
  logic       word_par;
  logic       row_end;

  // stage 2, output buffer write
  logic       v2;
  word_addr_t a2;
  bit_word_t  bits2;
  logic       last2;

  // row results
  logic       row_par;
  err_t       err;

  // --------------------
  // geometry
  // --------------------

  assign itag = rd.rtag;
  assign xlog = code_len_log2(btc_code_mode_t'(itag[TAG_XMODE_LSB +: MODE_W]));
  assign ylog = code_len_log2(btc_code_mode_t'(itag[TAG_YMODE_LSB +: MODE_W]));

  // words per row minus one, rows hold 1, 2 or 4 words
  assign row_mask  = word_addr_t'((1 << (xlog - LANE_LOG2)) - 1);
  assign last_addr = word_addr_t'((1 << (xlog + ylog - LANE_LOG2)) - 1);
  assign rd_last   = (raddr == last_addr);

  // --------------------
  // read side
  // --------------------

  // starts only with a frame in and room out
  always_ff @(posedge iclkin) begin
    if (rst) begin
      state <= ENG_IDLE;
      raddr <= '0;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (rd.rfull && wr.wempty) begin
            state <= ENG_READ;
            raddr <= '0;
          end
        end
        ENG_READ: begin
          if (rd_last) begin
            state <= ENG_DRAIN;
          end else begin
            raddr <= raddr + 1'b1;
          end
        end
        ENG_DRAIN: begin
          // wait for the last word to leave stage 2
          if (v2 && last2) begin
            state <= ENG_IDLE;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  assign rd.raddr = raddr;

  // --------------------
  // decision and parity
  // --------------------

  assign rword = rd.rdat;

  // sign bit per lane, negative LLR gives 1
  always_comb begin
    for (int i = 0; i < `BTC_DEC_NUM; i++) begin
      dec_bits[i] = rword[i*$bits(llr_t) + $bits(llr_t) - 1];
    end
  end

  assign word_par = ^dec_bits;
  assign row_end  = ((a1 & row_mask) == row_mask);

  always_ff @(posedge iclkin) begin
    if (rst) begin
      v1      <= 1'b0;
      v2      <= 1'b0;
      row_par <= 1'b0;
      err     <= '0;
    end else begin
      v1 <= (state == ENG_READ);
      v2 <= v1;
      if (state == ENG_IDLE) begin
        row_par <= 1'b0;
        err     <= '0;
      end else if (v1) begin
        if (row_end) begin
          // odd row counts as a failed check
          row_par <= 1'b0;
          if (row_par ^ word_par) begin
            err <= err + 1'b1;
          end
        end else begin
          row_par <= row_par ^ word_par;
        end
      end
    end
  end

  // address and bits ride along the valids
  always_ff @(posedge iclkin) begin
    a1    <= raddr;
    last1 <= rd_last;
    a2    <= a1;
    bits2 <= dec_bits;
    last2 <= last1;
  end

  // --------------------
  // write side
  // --------------------

  // err is final once the last word reaches stage 2
  assign otag = {(err != '0), err, itag};

  assign wr.write  = v2;
  assign wr.waddr  = a2;
  assign wr.wdat   = bits2;
  assign wr.wfull  = v2 && last2;
  assign wr.wtag   = otag;
  assign rd.rempty = v2 && last2;

endmodule

`default_nettype wire

/* btc_dec_sink.sv */
// serial bit readout on request with framing and result outputs
`timescale 1ns/1ps
`default_nettype none

module btc_dec_sink (
  input  logic               iclkin,
  input  logic               rst,
  input  logic               ireq,
  output logic               ofull,
  output logic               oval,
  output logic               osop,
  output logic               oeop,
  output logic               odat,
  output logic               odecfail,
  output btc_data_pkg::tag_t otag,
  output btc_data_pkg::err_t oerr,
  output btc_data_pkg::err_t onum,
  btc_buf_if.reader          rd
);

  import btc_mode_pkg::*;
  import btc_data_pkg::*;

  sink_state_t state;
  obuf_raddr_t raddr;
  err_t        num;
  logic        rd_first;
  logic        rd_last;
  logic        reading;

  // bit count from the stored modes
  assign num = err_t'(1) << (code_len_log2(btc_code_mode_t'(rd.rtag[TAG_XMODE_LSB +: MODE_W]))
                           + code_len_log2(btc_code_mode_t'(rd.rtag[TAG_YMODE_LSB +: MODE_W])));

  assign reading  = (state == SINK_READ);
  assign rd_first = (raddr == '0);
  assign rd_last  = (err_t'(raddr) == num - 1'b1);

  // --------------------
  // readout fsm
  // --------------------

  always_ff @(posedge iclkin) begin
    if (rst) begin
      state <= SINK_IDLE;
      raddr <= '0;
    end else begin
      case (state)
        SINK_IDLE: begin
          // requests without a frame are dropped
          if (ireq && rd.rfull) begin
            state <= SINK_READ;
            raddr <= '0;
          end
        end
        SINK_READ: begin
          raddr <= raddr + 1'b1;
          if (rd_last) begin
            state <= SINK_EOP;
          end
        end
        // last bit on the output
        SINK_EOP:     state <= SINK_RELEASE;
        SINK_RELEASE: state <= SINK_IDLE;
        default:      state <= SINK_IDLE;
      endcase
    end
  end

  assign rd.raddr  = raddr;
  assign rd.rempty = (state == SINK_RELEASE);

  // --------------------
  // output framing
  // --------------------

  // one cycle behind the address, as the read data
  always_ff @(posedge iclkin) begin
    if (rst) begin
      oval <= 1'b0;
      osop <= 1'b0;
      oeop <= 1'b0;
    end else begin
      oval <= reading;
      osop <= reading && rd_first;
      oeop <= reading && rd_last;
    end
  end

  assign ofull    = rd.rfull;
  assign odat     = rd.rdat[0];
  // results stay put while the frame is held
  assign otag     = rd.rtag[$bits(tag_t)-1:0];
  assign oerr     = rd.rtag[OT_ERR_LSB +: $bits(err_t)];
  assign odecfail = rd.rtag[OT_DECFAIL_BIT];
  assign onum     = num;

endmodule

`default_nettype wire

/* btc_dec.sv */
// decoder top level with source, buffers, engine and sink
`timescale 1ns/1ps
`default_nettype none

`include "btc_settings.svh"

module btc_dec (
  input  logic                         iclkin,
  input  logic                         rst,
  input  logic                         ival,
  input  logic                         isop,
  input  logic                         ieop,
  input  logic                         ireq,
  input  btc_mode_pkg::btc_code_mode_t ixmode,
  input  btc_mode_pkg::btc_code_mode_t iymode,
  input  btc_data_pkg::llr_t           illr,
  input  btc_data_pkg::tag_t           itag,
  output logic                         ordy,
  output logic                         obusy,
  output logic                         ofull,
  output logic                         oval,
  output logic                         osop,
  output logic                         oeop,
  output logic                         odat,
  output logic                         odecfail,
  output btc_data_pkg::tag_t           otag,
  output btc_data_pkg::err_t           oerr,
  output btc_data_pkg::err_t           onum
);

  import btc_data_pkg::*;

  // --------------------
  // buffer links
  // --------------------

  // LLRs in, words of eight LLRs out
  btc_buf_if #(
    .WADDR_W ($bits(ibuf_waddr_t)),
    .WDAT_W  ($bits(llr_t)),
    .RADDR_W ($bits(word_addr_t)),
    .RDAT_W  ($bits(llr_word_t)),
    .TAG_W   ($bits(in_tag_t))
  ) ibuf_if ();

  // words of eight bits in, single bits out
  btc_buf_if #(
    .WADDR_W ($bits(word_addr_t)),
    .WDAT_W  ($bits(bit_word_t)),
    .RADDR_W ($bits(obuf_raddr_t)),
    .RDAT_W  (1),
    .TAG_W   ($bits(out_tag_t))
  ) obuf_if ();

  // --------------------
  // frame path
  // --------------------

  btc_dec_source source (
    .iclkin (iclkin),
    .rst    (rst),
    .ival   (ival),
    .isop   (isop),
    .ieop   (ieop),
    .llr    (illr),
    .tag    (itag),
    .xmode  (ixmode),
    .ymode  (iymode),
    .ordy   (ordy),
    .obusy  (obusy),
    .wr     (ibuf_if)
  );

  btc_dwc_buffer #(
    .WDAT_W        ($bits(llr_t)),
    .WR_RATIO_LOG2 (-$clog2(`BTC_DEC_NUM))
  ) ibuffer (
    .iclkin (iclkin),
    .rst    (rst),
    .bus    (ibuf_if)
  );

  btc_dec_engine engine (
    .iclkin (iclkin),
    .rst    (rst),
    .rd     (ibuf_if),
    .wr     (obuf_if)
  );

  btc_dwc_buffer #(
    .WDAT_W        ($bits(bit_word_t)),
    .WR_RATIO_LOG2 ($clog2(`BTC_DEC_NUM))
  ) obuffer (
    .iclkin (iclkin),
    .rst    (rst),
    .bus    (obuf_if)
  );

  btc_dec_sink sink (
    .iclkin   (iclkin),
    .rst      (rst),
    .ireq     (ireq),
    .ofull    (ofull),
    .oval     (oval),
    .osop     (osop),
    .oeop     (oeop),
    .odat     (odat),
    .odecfail (odecfail),
    .otag     (otag),
    .oerr     (oerr),
    .onum     (onum),
    .rd       (obuf_if)
  );

endmodule

`default_nettype wire

/* btc_dec_properties.sv */
// concurrent assertions on the decoder top level ports, bound to btc_dec
`timescale 1ns/1ps
`default_nettype none

module btc_dec_properties (
  input logic iclkin,
  input logic rst,
  input logic ordy,
  input logic obusy,
  input logic ofull,
  input logic oval,
  input logic osop,
  input logic oeop
);

  // readout only from a held frame
  a_oval_full: assert property (@(posedge iclkin) disable iff (rst) oval |-> ofull)
    else $error("oval high while ofull is low");

  // framing strobes sit on valid beats
  a_sop_val: assert property (@(posedge iclkin) disable iff (rst) osop |-> oval)
    else $error("osop high without oval");

  a_eop_val: assert property (@(posedge iclkin) disable iff (rst) oeop |-> oval)
    else $error("oeop high without oval");

  // source is either open for a frame or inside one
  a_rdy_busy: assert property (@(posedge iclkin) disable iff (rst) !(ordy && obusy))
    else $error("ordy and obusy high together");

endmodule

bind btc_dec btc_dec_properties props (
  .iclkin (iclkin),
  .rst    (rst),
  .ordy   (ordy),
  .obusy  (obusy),
  .ofull  (ofull),
  .oval   (oval),
  .osop   (osop),
  .oeop   (oeop)
);

`default_nettype wire

/* tb_btc_checker.sv */
// output watcher comparing each readout against expected frames, with counters
`timescale 1ns/1ps
`default_nettype none

module tb_btc_checker (
  input  logic               iclkin,
  input  logic               rst,
  input  logic               oval,
  input  logic               osop,
  input  logic               oeop,
  input  logic               odat,
  input  logic               odecfail,
  input  btc_data_pkg::tag_t otag,
  input  btc_data_pkg::err_t oerr,
  input  btc_data_pkg::err_t onum,
  output int                 frames,
  output int                 fails
);

  import btc_data_pkg::*;

  // expected frames in send order
  string      name_q [$];
  tag_t       tag_q [$];
  err_t       err_q [$];
  err_t       num_q [$];
  logic       fail_q [$];
  logic       bit_q [$];

  logic       in_frame;
  logic       stray;
  string      cur_name;
  tag_t       cur_tag;
  err_t       cur_err;
  err_t       cur_num;
  logic       cur_fail;
  int         nbits;
  int         bad_bits;
  // otag, oerr, onum, odecfail, length
  logic [4:0] bad_field;

  task automatic add_bit(input logic b);
    bit_q.push_back(b);
  endtask

  task automatic add_frame(input string name, input tag_t tag, input err_t err,
                           input err_t num, input logic decfail);
    name_q.push_back(name);
    tag_q.push_back(tag);
    err_q.push_back(err);
    num_q.push_back(num);
    fail_q.push_back(decfail);
  endtask

  // first mismatch of each field per frame
  task automatic field_check(input string field, input int idx,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual && !bad_field[idx]) begin
      $display("[FAIL] %s %s expected %0d actual %0d", cur_name, field, expected, actual);
      bad_field[idx] = 1'b1;
    end
  endtask

  task automatic open_frame();
    if (name_q.size() == 0) begin
      $display("osop arrived but no frame was expected");
      fails++;
      stray = 1'b1;
    end else begin
      cur_name  = name_q.pop_front();
      cur_tag   = tag_q.pop_front();
      cur_err   = err_q.pop_front();
      cur_num   = num_q.pop_front();
      cur_fail  = fail_q.pop_front();
      nbits     = 0;
      bad_bits  = 0;
      bad_field = '0;
      in_frame  = 1'b1;
    end
  endtask

  task automatic compare_beat();
    logic exp_bit;
    field_check("otag", 0, cur_tag, otag);
    field_check("oerr", 1, cur_err, oerr);
    field_check("onum", 2, cur_num, onum);
    field_check("odecfail", 3, cur_fail, odecfail);
    exp_bit = bit_q.pop_front();
    if (odat !== exp_bit) begin
      if (bad_bits == 0) begin
        $display("[FAIL] %s odat bit %0d expected %0d actual %0d",
                 cur_name, nbits, exp_bit, odat);
      end
      bad_bits++;
    end
    nbits++;
  endtask

  task automatic close_frame();
    field_check("readout length", 4, cur_num, nbits);
    // drop bits a short readout never reached
    for (int i = nbits; i < cur_num; i++) begin
      void'(bit_q.pop_front());
    end
    $display("frame %s done, %0d bits, %0d bit errors", cur_name, nbits, bad_bits);
    if (bad_bits != 0 || bad_field != '0) begin
      fails++;
    end
    frames++;
    in_frame = 1'b0;
  endtask

  initial begin
    frames   = 0;
    fails    = 0;
    in_frame = 1'b0;
    stray    = 1'b0;
  end

  // --------------------
  // watcher
  // --------------------

  // mid-cycle sampling, outputs settled
  always @(negedge iclkin) begin
    if (!rst) begin
      if (oval && osop) begin
        if (in_frame) begin
          $display("oeop missing, frame %s cut short by a new osop", cur_name);
          fails++;
          close_frame();
        end
        open_frame();
      end else if (oval && !in_frame) begin
        if (!stray) begin
          $display("oval outside a frame, osop missing");
          fails++;
          stray = 1'b1;
        end
      end else if (!oval && (osop || oeop)) begin
        $display("osop or oeop came without oval");
        fails++;
      end else if (!oval && in_frame) begin
        $display("oval dropped in the middle of frame %s", cur_name);
        fails++;
        close_frame();
      end
      if (!oval) begin
        stray = 1'b0;
      end
      if (oval && in_frame) begin
        compare_beat();
        if (oeop) begin
          close_frame();
        end else if (nbits == cur_num) begin
          $display("oeop missing at the last bit of frame %s", cur_name);
          fails++;
          close_frame();
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb_btc_dec.sv */
// testbench top with clock, reset, LFSR stimulus, reference model and test sequence
`timescale 1ns/1ps
`default_nettype none

module tb_btc_dec;

  import btc_mode_pkg::*;
  import btc_data_pkg::*;

  // cycles any single wait may take
  localparam int WAIT_MAX = 4000;

  logic           iclkin;
  logic           rst;
  logic           ival;
  logic           isop;
  logic           ieop;
  logic           ireq;
  btc_code_mode_t ixmode;
  btc_code_mode_t iymode;
  llr_t           illr;
  tag_t           itag;
  logic           ordy;
  logic           obusy;
  logic           ofull;
  logic           oval;
  logic           osop;
  logic           oeop;
  logic           odat;
  logic           odecfail;
  tag_t           otag;
  err_t           oerr;
  err_t           onum;

  int             chk_frames;
  int             chk_fails;
  int             tb_errors;
  int             frames_sent;
  logic [31:0]    lfsr_state;
  tag_t           next_tag;

  // current frame and its expected bits
  llr_t           frame_llr [FRAME_BITS_MAX];
  logic           ref_bits  [FRAME_BITS_MAX];

  btc_dec dut0 (
    .iclkin   (iclkin),
    .rst      (rst),
    .ival     (ival),
    .isop     (isop),
    .ieop     (ieop),
    .ireq     (ireq),
    .ixmode   (ixmode),
    .iymode   (iymode),
    .illr     (illr),
    .itag     (itag),
    .ordy     (ordy),
    .obusy    (obusy),
    .ofull    (ofull),
    .oval     (oval),
    .osop     (osop),
    .oeop     (oeop),
    .odat     (odat),
    .odecfail (odecfail),
    .otag     (otag),
    .oerr     (oerr),
    .onum     (onum)
  );

  tb_btc_checker chk (
    .iclkin   (iclkin),
    .rst      (rst),
    .oval     (oval),
    .osop     (osop),
    .oeop     (oeop),
    .odat     (odat),
    .odecfail (odecfail),
    .otag     (otag),
    .oerr     (oerr),
    .onum     (onum),
    .frames   (chk_frames),
    .fails    (chk_fails)
  );

  // 10 ns clock
  initial iclkin = 1'b0;
  always #5 iclkin = ~iclkin;

  // --------------------
  // random source and reference
  // --------------------

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic int mode_len(input btc_code_mode_t m);
    case (m)
      CODE_LEN_8:  return 8;
      CODE_LEN_16: return 16;
      default:     return 32;
    endcase
  endfunction

  // sign decisions, odd rows and bit count of frame_llr
  function automatic void btc_ref(input int xlen, input int ylen,
                                  output int err, output int num);
    logic par;
    err = 0;
    num = xlen * ylen;
    for (int r = 0; r < ylen; r++) begin
      par = 1'b0;
      for (int c = 0; c < xlen; c++) begin
        ref_bits[r*xlen + c] = (frame_llr[r*xlen + c] < 0);
        par = par ^ ref_bits[r*xlen + c];
      end
      if (par) begin
        err++;
      end
    end
  endfunction

  // --------------------
  // run control
  // --------------------

  task automatic end_run();
    $display("frames sent %0d, frames checked %0d, checker errors %0d, sequence errors %0d",
             frames_sent, chk_frames, chk_fails, tb_errors);
    if (chk_fails == 0 && tb_errors == 0 && chk_frames == frames_sent) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
      tb_errors++;
    end
  endtask

  task automatic test_done(input int n, input string name);
    $display("test %0d %s finished, errors so far %0d", n, name, chk_fails + tb_errors);
  endtask

  // --------------------
  // bounded waits
  // --------------------

  task automatic wait_ordy(input string what);
    int n;
    n = 0;
    while (ordy !== 1'b1 && n < WAIT_MAX) begin
      @(negedge iclkin);
      n++;
    end
    if (ordy !== 1'b1) begin
      $display("timeout, ordy never rose before %s", what);
      tb_errors++;
      end_run();
    end
  endtask

  task automatic wait_ofull(input logic level, input string what);
    int n;
    n = 0;
    while (ofull !== level && n < WAIT_MAX) begin
      @(negedge iclkin);
      n++;
    end
    if (ofull !== level) begin
      $display("timeout, ofull never went to %0d during %s", level, what);
      tb_errors++;
      end_run();
    end
  endtask

  task automatic wait_oeop(input string what);
    int n;
    n = 0;
    while (oeop !== 1'b1 && n < WAIT_MAX) begin
      @(negedge iclkin);
      n++;
    end
    if (oeop !== 1'b1) begin
      $display("timeout, no oeop in the readout of %s", what);
      tb_errors++;
      end_run();
    end
  endtask

  // --------------------
  // frame traffic
  // --------------------

  // random LLRs, or only non-negative ones when positive is set
  task automatic send_frame(input string name, input btc_code_mode_t xm,
                            input btc_code_mode_t ym, input logic positive);
    int          xlen;
    int          ylen;
    int          err;
    int          num;
    logic [31:0] v;
    xlen = mode_len(xm);
    ylen = mode_len(ym);
    for (int k = 0; k < xlen * ylen; k++) begin
      take_bits(8, v);
      frame_llr[k] = positive ? llr_t'({1'b0, v[6:0]}) : llr_t'(v[7:0]);
    end
    btc_ref(xlen, ylen, err, num);
    for (int k = 0; k < num; k++) begin
      chk.add_bit(ref_bits[k]);
    end
    chk.add_frame(name, next_tag, err_t'(err), err_t'(num), err != 0);
    wait_ordy(name);
    for (int k = 0; k < num; k++) begin
      ival   = 1'b1;
      isop   = (k == 0);
      ieop   = (k == num - 1);
      illr   = frame_llr[k];
      itag   = next_tag;
      ixmode = xm;
      iymode = ym;
      @(negedge iclkin);
      // source busy once isop is taken
      if (k == 0) begin
        check_value("frame obusy", 1, obusy);
      end
    end
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
    // input buffer full once ieop is taken
    check_value("frame end ordy", 0, ordy);
    check_value("frame end obusy", 0, obusy);
    next_tag++;
    frames_sent++;
  endtask

  // one ireq pulse, optional second pulse inside the readout
  task automatic read_frame(input string what, input logic extra_req);
    wait_ofull(1'b1, what);
    ireq = 1'b1;
    @(negedge iclkin);
    ireq = 1'b0;
    if (extra_req) begin
      repeat (5) @(negedge iclkin);
      ireq = 1'b1;
      @(negedge iclkin);
      ireq = 1'b0;
    end
    wait_oeop(what);
    wait_ofull(1'b0, what);
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial begin
    rst         = 1'b1;
    ival        = 1'b0;
    isop        = 1'b0;
    ieop        = 1'b0;
    ireq        = 1'b0;
    ixmode      = CODE_LEN_8;
    iymode      = CODE_LEN_8;
    illr        = '0;
    itag        = '0;
    tb_errors   = 0;
    frames_sent = 0;
    next_tag    = 8'h10;
    lfsr_state  = 32'hecc921db;
    repeat (8) @(negedge iclkin);
    rst = 1'b0;
    @(negedge iclkin);

    // idle levels, then a request with nothing stored
    check_value("reset ordy", 1, ordy);
    check_value("reset obusy", 0, obusy);
    check_value("reset ofull", 0, ofull);
    check_value("reset oval", 0, oval);
    ireq = 1'b1;
    @(negedge iclkin);
    ireq = 1'b0;
    repeat (30) begin
      @(negedge iclkin);
      check_value("idle ireq oval", 0, oval);
    end
    test_done(1, "reset and idle request");

    send_frame("rand_8x8", CODE_LEN_8, CODE_LEN_8, 1'b0);
    read_frame("rand_8x8", 1'b0);
    test_done(2, "random 8x8 frame");

    // every geometry, then one frame with no negative LLR
    for (int xm = 0; xm < 3; xm++) begin
      for (int ym = 0; ym < 3; ym++) begin
        send_frame($sformatf("rand_%0dx%0d", mode_len(btc_code_mode_t'(xm)),
                             mode_len(btc_code_mode_t'(ym))),
                   btc_code_mode_t'(xm), btc_code_mode_t'(ym), 1'b0);
        read_frame("mode sweep", 1'b0);
      end
    end
    send_frame("positive_16x32", CODE_LEN_16, CODE_LEN_32, 1'b1);
    read_frame("positive_16x32", 1'b0);
    test_done(3, "mode sweep");

    next_tag = 8'ha5;
    send_frame("tag_a5_32x16", CODE_LEN_32, CODE_LEN_16, 1'b0);
    read_frame("tag_a5_32x16", 1'b0);
    next_tag = 8'h5a;
    send_frame("tag_5a_8x32", CODE_LEN_8, CODE_LEN_32, 1'b0);
    read_frame("tag_5a_8x32", 1'b0);
    test_done(4, "tag pass through");

    // two frames fill both buffers
    send_frame("bp_f1_8x8", CODE_LEN_8, CODE_LEN_8, 1'b0);
    send_frame("bp_f2_16x8", CODE_LEN_16, CODE_LEN_8, 1'b0);
    check_value("backpressure ofull", 1, ofull);
    repeat (10) begin
      ival = 1'b1;
      isop = 1'b1;
      illr = 8'sh80;
      @(negedge iclkin);
      ival = 1'b0;
      isop = 1'b0;
      check_value("backpressure ordy", 0, ordy);
      check_value("backpressure obusy", 0, obusy);
      @(negedge iclkin);
    end
    read_frame("bp_f1_8x8", 1'b0);
    send_frame("bp_f3_32x8", CODE_LEN_32, CODE_LEN_8, 1'b0);
    read_frame("bp_f2_16x8", 1'b0);
    read_frame("bp_f3_32x8", 1'b0);
    test_done(5, "back-pressure");

    // second ireq lands inside the readout
    send_frame("timing_32x8", CODE_LEN_32, CODE_LEN_8, 1'b0);
    read_frame("timing_32x8", 1'b1);
    repeat (30) begin
      @(negedge iclkin);
      check_value("after readout oval", 0, oval);
    end
    test_done(6, "readout timing");

    end_run();
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
btc_mode_pkg.sv
btc_data_pkg.sv
btc_buf_if.sv
btc_dwc_buffer.sv
btc_dec_source.sv
btc_dec_engine.sv
btc_dec_sink.sv
btc_dec.sv
btc_dec_properties.sv
tb_btc_checker.sv
tb_btc_dec.sv
